/* logic/fb_pkg.sv */
`default_nettype none

package fb_pkg;

    // ------------------------------------------------------------------------
    // display geometry, scaled down raster
    // ------------------------------------------------------------------------
    localparam int h_disp      = 16;    // visible columns
    localparam int v_disp      = 8;     // visible lines
    localparam int h_total     = 20;    // columns per line incl. blanking
    localparam int v_total     = 10;    // lines per frame incl. blanking
    localparam int hsync_start = 17;    // first hsync column
    localparam int hsync_end   = 18;    // last hsync column, inclusive
    localparam int vsync_line  = 9;     // vsync high for this whole line

    // memory sizing, two buffers back to back
    localparam int buf_words = 128;     // h_disp * v_disp
    localparam int mem_words = 256;

    // ------------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------------
    typedef logic [3:0]  x_t;           // visible column
    typedef logic [2:0]  y_t;           // visible line
    typedef logic [4:0]  h_cnt_t;       // raster column, 0..h_total-1
    typedef logic [3:0]  v_cnt_t;       // raster line, 0..v_total-1
    typedef logic [6:0]  pix_addr_t;    // pixel index inside one buffer
    typedef logic [7:0]  fb_addr_t;     // {buffer bit, pix_addr_t}
    typedef logic [23:0] rgb_t;
    typedef logic [7:0]  span_len_t;    // 1..128 pixels

    // drawing command, sampled when enable is seen in idle
    typedef struct packed {
        x_t        x_pos;
        y_t        y_pos;
        rgb_t      pixel;
        span_len_t len;
    } span_cmd_t;

    // one access on the shared memory port
    typedef struct packed {
        logic     req;
        logic     we;
        fb_addr_t addr;
        rgb_t     wdata;
    } mem_req_t;

    // display side, de plus syncs plus colour
    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } pixel_out_t;

    typedef enum logic [1:0] {
        idle,   // waiting for enable
        fill,   // writing pixels, busy high
        hold    // done, waiting for enable to drop
    } writer_state_t;

endpackage

`default_nettype wire

/* logic/frame_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_memory (
    input  wire  logic             clk,
    input  wire  logic             rst,
    input  wire  fb_pkg::mem_req_t mem,
    output       fb_pkg::rgb_t     q,
    output       logic             ready
);

    fb_pkg::rgb_t     ram [fb_pkg::mem_words];  // ping at 0..127, pong at 128..255
    fb_pkg::fb_addr_t clr_addr;                 // clear sweep pointer

    // ------------------------------------------------------------------------
    // clear sweep, stands in for sdram init
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end else if (!ready) begin
            clr_addr <= clr_addr + 1'b1;
            // last word cleared this cycle
            if (clr_addr == fb_pkg::fb_addr_t'(fb_pkg::mem_words - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    // write port, sweep owns it until ready
    always_ff @(posedge clk) begin
        if (!ready) begin
            ram[clr_addr] <= '0;
        end else if (mem.req && mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // read data one cycle after the grant
    always_ff @(posedge clk) begin
        if (mem.req && !mem.we) begin
            q <= ram[mem.addr];
        end
    end

endmodule

`default_nettype wire

/* logic/frame_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_arbiter (
    input  wire  logic             ready,
    input  wire  fb_pkg::mem_req_t rd_req,      // scan-out, highest priority
    input  wire  fb_pkg::mem_req_t wr_req,      // span writer
    input  wire  fb_pkg::rgb_t     q,           // from memory
    output       logic             rd_gnt,
    output       logic             wr_gnt,
    output       fb_pkg::rgb_t     rd_data,     // back to reader
    output       fb_pkg::mem_req_t mem
);

    // ------------------------------------------------------------------------
    // fixed priority grant
    // ------------------------------------------------------------------------
    // reader cannot stall, so it always wins; writer takes the gaps
    // (blanking and the columns past h_disp)
    always_comb begin
        rd_gnt = 1'b0;
        wr_gnt = 1'b0;
        if (ready) begin                    // nothing before clear is done
            if (rd_req.req) begin
                rd_gnt = 1'b1;
            end else if (wr_req.req) begin
                wr_gnt = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // port mux
    // ------------------------------------------------------------------------
    always_comb begin
        mem = '0;                           // idle port, req low
        if (rd_gnt) begin
            mem       = rd_req;
            mem.we    = 1'b0;               // reader never writes
            mem.wdata = '0;
        end else if (wr_gnt) begin
            mem    = wr_req;
            mem.we = 1'b1;
        end
    end

    // only the reader ever issues reads, so q belongs to it
    assign rd_data = q;

endmodule

`default_nettype wire

/* logic/span_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module span_writer (
    input  wire  logic              clk,
    input  wire  logic              rst,
    input  wire  logic              ready,
    input  wire  logic              buf_sel,
    input  wire  fb_pkg::span_cmd_t span,
    input  wire  logic              enable,
    output       logic              busy,
    output       fb_pkg::mem_req_t  wr_req,
    input  wire  logic              wr_gnt
);

    fb_pkg::writer_state_t state;
    fb_pkg::pix_addr_t     start_idx;   // y * h_disp + x of the command
    fb_pkg::span_len_t     room;        // pixels left up to buffer end
    fb_pkg::span_len_t     clip_len;    // len clipped to room
    fb_pkg::pix_addr_t     wr_idx;      // current pixel index
    fb_pkg::span_len_t     remain;      // pixels still to write
    fb_pkg::rgb_t          colour;      // latched span colour
    logic                  wr_buf;      // back buffer bit

    // ------------------------------------------------------------------------
    // command decode
    // ------------------------------------------------------------------------
    always_comb begin
        start_idx = fb_pkg::pix_addr_t'(span.y_pos) * fb_pkg::pix_addr_t'(fb_pkg::h_disp)
                    + fb_pkg::pix_addr_t'(span.x_pos);
        room      = fb_pkg::span_len_t'(fb_pkg::buf_words) - fb_pkg::span_len_t'(start_idx);
        // no wrap into the other buffer
        clip_len  = (span.len > room) ? room : span.len;
    end

    // ------------------------------------------------------------------------
    // fsm
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= fb_pkg::idle;
            remain <= '0;
        end else begin
            case (state)
                fb_pkg::idle: begin
                    if (enable && ready) begin
                        remain <= clip_len;
                        // zero length, nothing to draw
                        state  <= (clip_len == '0) ? fb_pkg::hold : fb_pkg::fill;
                    end
                end
                fb_pkg::fill: begin
                    if (wr_gnt) begin
                        remain <= remain - 1'b1;
                        if (remain == fb_pkg::span_len_t'(1)) begin
                            state <= fb_pkg::hold;  // last pixel just written
                        end
                    end
                end
                fb_pkg::hold: begin
                    if (!enable) begin
                        state <= fb_pkg::idle;
                    end
                end
                default: state <= fb_pkg::idle;
            endcase
        end
    end

    // payload, loaded on accept and stepped per grant
    always_ff @(posedge clk) begin
        if (state == fb_pkg::idle && enable && ready) begin
            wr_idx <= start_idx;
            colour <= span.pixel;
            wr_buf <= ~buf_sel;             // front is buf_sel, write the other
        end else if (state == fb_pkg::fill && wr_gnt) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    assign busy = (state == fb_pkg::fill);

    // request held until granted
    always_comb begin
        wr_req.req   = (state == fb_pkg::fill);
        wr_req.we    = 1'b1;
        wr_req.addr  = {wr_buf, wr_idx};
        wr_req.wdata = colour;
    end

endmodule

`default_nettype wire

/* logic/scanout_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module scanout_reader (
    input  wire  logic               clk,
    input  wire  logic               rst,
    input  wire  logic               ready,
    input  wire  logic               buf_sel,
    output       fb_pkg::mem_req_t   rd_req,
    input  wire  logic               rd_gnt,
    input  wire  fb_pkg::rgb_t       rd_data,
    output       fb_pkg::pixel_out_t pix
);

    fb_pkg::h_cnt_t    h_cnt;           // raster column
    fb_pkg::v_cnt_t    v_cnt;           // raster line
    logic              frame_start;
    logic              front;           // buffer on display this frame
    logic              front_q;
    logic              visible;
    logic              hs;
    logic              vs;
    fb_pkg::pix_addr_t rd_idx;

    // de and syncs, one stage behind the counters
    logic              de_q;
    logic              hs_q;
    logic              vs_q;

    // ------------------------------------------------------------------------
    // raster counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (ready) begin       // held at 0,0 until memory is cleared
            if (h_cnt == fb_pkg::h_cnt_t'(fb_pkg::h_total - 1)) begin
                h_cnt <= '0;
                if (v_cnt == fb_pkg::v_cnt_t'(fb_pkg::v_total - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // front buffer, swap only at frame start
    // ------------------------------------------------------------------------
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);
    assign front       = frame_start ? buf_sel : front_q;   // first read already uses it

    always_ff @(posedge clk) begin
        if (rst) begin
            front_q <= 1'b0;
        end else begin
            front_q <= front;
        end
    end

    // ------------------------------------------------------------------------
    // read request and sync decode
    // ------------------------------------------------------------------------
    always_comb begin
        visible = ready
                  && (h_cnt < fb_pkg::h_cnt_t'(fb_pkg::h_disp))
                  && (v_cnt < fb_pkg::v_cnt_t'(fb_pkg::v_disp));
        hs      = ready
                  && (h_cnt >= fb_pkg::h_cnt_t'(fb_pkg::hsync_start))
                  && (h_cnt <= fb_pkg::h_cnt_t'(fb_pkg::hsync_end));
        vs      = ready && (v_cnt == fb_pkg::v_cnt_t'(fb_pkg::vsync_line));
        rd_idx  = fb_pkg::pix_addr_t'(fb_pkg::y_t'(v_cnt)) * fb_pkg::pix_addr_t'(fb_pkg::h_disp)
                  + fb_pkg::pix_addr_t'(fb_pkg::x_t'(h_cnt));
    end

    always_comb begin
        rd_req.req   = visible;
        rd_req.we    = 1'b0;
        rd_req.addr  = {front, rd_idx};
        rd_req.wdata = '0;
    end

    // ------------------------------------------------------------------------
    // output stage, lines up with q from memory
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= rd_gnt;             // data returns the cycle after grant
            hs_q <= hs;
            vs_q <= vs;
        end
    end

    always_comb begin
        pix.de    = de_q;
        pix.hsync = hs_q;
        pix.vsync = vs_q;
        pix.rgb   = de_q ? rd_data : '0;    // q is stale outside de
    end

endmodule

`default_nettype wire

/* logic/framebuffer_display.sv */
`timescale 1ns/10ps
`default_nettype none

module framebuffer_display (
    input  wire  logic               clk,
    input  wire  logic               rst,
    input  wire  logic               buf_sel,   // 1: draw ping, show pong
    input  wire  fb_pkg::span_cmd_t  span,
    input  wire  logic               enable,
    output       logic               busy,
    output       logic               ready,     // memory cleared
    output       fb_pkg::pixel_out_t pix
);

    // ------------------------------------------------------------------------
    // memory bus between the peers and the arbiter
    // ------------------------------------------------------------------------
    fb_pkg::mem_req_t wr_req;
    fb_pkg::mem_req_t rd_req;
    fb_pkg::mem_req_t mem;
    logic             wr_gnt;
    logic             rd_gnt;
    fb_pkg::rgb_t     rd_data;
    fb_pkg::rgb_t     q;

    // drawing side, fills back buffer
    span_writer span_writer_i (
        .clk     (clk),
        .rst     (rst),
        .ready   (ready),
        .buf_sel (buf_sel),
        .span    (span),
        .enable  (enable),
        .busy    (busy),
        .wr_req  (wr_req),
        .wr_gnt  (wr_gnt)
    );

    // display side, streams front buffer
    scanout_reader scanout_reader_i (
        .clk     (clk),
        .rst     (rst),
        .ready   (ready),
        .buf_sel (buf_sel),
        .rd_req  (rd_req),
        .rd_gnt  (rd_gnt),
        .rd_data (rd_data),
        .pix     (pix)
    );

    frame_arbiter frame_arbiter_i (
        .ready   (ready),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .q       (q),
        .rd_gnt  (rd_gnt),
        .wr_gnt  (wr_gnt),
        .rd_data (rd_data),
        .mem     (mem)
    );

    frame_memory frame_memory_i (
        .clk   (clk),
        .rst   (rst),
        .mem   (mem),
        .q     (q),
        .ready (ready)
    );

endmodule

`default_nettype wire

/* bench/framebuffer_display_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module framebuffer_display_assertions (
    input  wire  logic               clk,
    input  wire  logic               rst,
    input  wire  logic               ready,
    input  wire  logic               enable,
    input  wire  logic               busy,
    input  wire  logic               rd_gnt,
    input  wire  logic               wr_gnt,
    input  wire  fb_pkg::pixel_out_t pix
);

    // ------------------------------------------------------------------------
    // bus and handshake rules
    // ------------------------------------------------------------------------
    // nothing drawn or shown until the clear sweep is done
    quiet_before_ready: assert property (@(posedge clk) disable iff (rst)
        !ready |-> (!busy && !pix.de))
        else $error("busy or de high while memory not ready");

    // single memory port, one owner per cycle
    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(rd_gnt && wr_gnt))
        else $error("reader and writer granted in the same cycle");

    // hsync sits in the horizontal blanking only
    hsync_in_blank: assert property (@(posedge clk) disable iff (rst)
        pix.hsync |-> !pix.de)
        else $error("hsync high during active video");

    // span accepted only on enable
    busy_needs_enable: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(enable))
        else $error("busy rose without enable in the cycle before");

endmodule

`default_nettype wire

/* bench/framebuffer_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module framebuffer_display_tb;

    localparam int timeout_cycles = 5000;   // clear + ~15 frames + margin
    localparam int frame_cycles   = fb_pkg::h_total * fb_pkg::v_total;

    logic               clk;
    logic               rst;
    logic               buf_sel;
    fb_pkg::span_cmd_t  span;
    logic               enable;
    logic               busy;
    logic               ready;
    fb_pkg::pixel_out_t pix;

    fb_pkg::rgb_t model [2][fb_pkg::buf_words];    // expected ping and pong
    logic [31:0]  lfsr_state;
    int           cycle_count;

    framebuffer_display dut_i (
        .clk     (clk),
        .rst     (rst),
        .buf_sel (buf_sel),
        .span    (span),
        .enable  (enable),
        .busy    (busy),
        .ready   (ready),
        .pix     (pix)
    );

    bind framebuffer_display framebuffer_display_assertions assertions_i (
        .clk    (clk),
        .rst    (rst),
        .ready  (ready),
        .enable (enable),
        .busy   (busy),
        .rd_gnt (rd_gnt),
        .wr_gnt (wr_gnt),
        .pix    (pix)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, tests still running after %0d cycles", timeout_cycles);
        $display("Test FAILED");
        $fatal(1, "stopped by watchdog");
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_colour(output fb_pkg::rgb_t colour);
        for (int i = 0; i < 24; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // one step per bit
            colour[i]  = lfsr_state[0];
        end
    endtask

    // linear pixel index that stops at the buffer end
    function automatic void model_span(input logic bank, input int x, input int y,
                                       input fb_pkg::rgb_t colour, input int len);
        int idx;
        idx = y * fb_pkg::h_disp + x;
        for (int i = 0; i < len && idx + i < fb_pkg::buf_words; i++) begin
            model[bank][idx + i] = colour;
        end
    endfunction

    task automatic set_span(input int x, input int y, input fb_pkg::rgb_t colour,
                            input int len);
        span.x_pos = fb_pkg::x_t'(x);
        span.y_pos = fb_pkg::y_t'(y);
        span.pixel = colour;
        span.len   = fb_pkg::span_len_t'(len);
    endtask

    task automatic draw_span(input int x, input int y, input fb_pkg::rgb_t colour,
                             input int len);
        @(negedge clk);
        set_span(x, y, colour, len);
        enable = 1'b1;
        model_span(~buf_sel, x, y, colour, len);    // back buffer
        @(negedge clk);
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);                // last write granted
        enable = 1'b0;
    endtask

    // flip during vblank so the reader takes it at the next frame start
    task automatic swap_buffers();
        @(negedge clk);
        while (!pix.vsync) @(negedge clk);
        buf_sel = ~buf_sel;
    endtask

    // first de after a gap longer than a line is pixel 0 of a frame
    task automatic wait_frame_start();
        int low_run;
        low_run = 0;
        @(negedge clk);
        while (!(pix.de && low_run > fb_pkg::h_total)) begin
            low_run = pix.de ? 0 : low_run + 1;
            @(negedge clk);
        end
    endtask

    // de pixels in raster order against the model
    task automatic compare_frame(input logic front);
        int idx;
        idx = 0;
        while (idx < fb_pkg::buf_words) begin
            if (pix.de) begin
                check_value(pix.rgb, model[front][idx],
                            $sformatf("pixel %0d of buffer %0d", idx, front));
                idx++;
            end
            @(negedge clk);
        end
    endtask

    task automatic check_frame(input logic front);
        wait_frame_start();
        compare_frame(front);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_and_clear();
        int clear_cycles;
        clear_cycles = 0;
        repeat (10) begin
            @(negedge clk);
            check_value(ready, 0, "ready during reset");
        end
        rst = 1'b0;
        while (!ready) begin
            @(negedge clk);
            clear_cycles++;
            check_value(pix.de, 0, "de before ready");
            check_value(busy, 0, "busy before ready");
        end
        check_value(clear_cycles, fb_pkg::mem_words, "cycles from reset release to ready");
        // raster starts at 0,0 with ready so the next de opens the first frame
        compare_frame(buf_sel);                     // all zero after clear
    endtask

    task automatic single_span();
        fb_pkg::rgb_t colour;
        random_colour(colour);
        draw_span(3, 2, colour, 5);
        swap_buffers();
        check_frame(buf_sel);
    endtask

    task automatic wrap_and_clip();
        fb_pkg::rgb_t colour_a;
        fb_pkg::rgb_t colour_b;
        random_colour(colour_a);
        random_colour(colour_b);
        draw_span(14, 1, colour_a, 6);      // runs onto line 2
        draw_span(10, 7, colour_b, 40);     // stops at 127
        swap_buffers();
        check_frame(buf_sel);
        swap_buffers();                     // other buffer must be untouched
        check_frame(buf_sel);
    endtask

    task automatic isolation();
        fb_pkg::rgb_t colour_a;
        fb_pkg::rgb_t colour_b;
        random_colour(colour_a);
        random_colour(colour_b);
        fork
            check_frame(buf_sel);           // front stays as it was
            begin
                draw_span(0, 0, colour_a, 16);
                draw_span(5, 3, colour_b, 9);
            end
        join
        swap_buffers();
        check_frame(buf_sel);
    endtask

    task automatic raster_timing();
        int   de_count;
        int   hs_pulses;
        int   vs_pulses;
        int   vs_len;
        logic hs_prev;
        logic vs_prev;
        de_count  = 0;
        hs_pulses = 0;
        vs_pulses = 0;
        vs_len    = 0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        wait_frame_start();
        for (int i = 0; i < frame_cycles; i++) begin
            if (pix.de) de_count++;
            if (pix.hsync && !hs_prev) hs_pulses++;
            if (pix.vsync && !vs_prev) vs_pulses++;
            if (pix.vsync) vs_len++;
            hs_prev = pix.hsync;
            vs_prev = pix.vsync;
            @(negedge clk);
        end
        check_value(de_count, fb_pkg::h_disp * fb_pkg::v_disp, "de cycles per frame");
        check_value(hs_pulses, fb_pkg::v_total, "hsync pulses per frame");
        check_value(vs_pulses, 1, "vsync pulses per frame");
        check_value(vs_len, fb_pkg::h_total, "vsync pulse length");
    endtask

    task automatic enable_protocol();
        fb_pkg::rgb_t colour_a;
        fb_pkg::rgb_t colour_b;
        random_colour(colour_a);
        random_colour(colour_b);
        @(negedge clk);
        set_span(2, 4, colour_a, 20);
        enable = 1'b1;
        model_span(~buf_sel, 2, 4, colour_a, 20);
        @(negedge clk);
        while (!busy) @(negedge clk);
        set_span(0, 6, colour_b, 8);        // new command while busy must not land
        enable = 1'b0;
        @(negedge clk);
        enable = 1'b1;
        while (busy) @(negedge clk);
        repeat (40) begin                   // enable held yet no second span
            @(negedge clk);
            check_value(busy, 0, "busy with enable held after span end");
        end
        enable = 1'b0;
        swap_buffers();
        check_frame(buf_sel);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        buf_sel    = 1'b0;                  // show ping and draw pong
        span       = '0;
        enable     = 1'b0;
        lfsr_state = 32'h2cdc5edc;
        model      = '{default: '0};
        reset_and_clear();
        single_span();
        wrap_and_clip();
        isolation();
        raster_timing();
        enable_protocol();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* framebuffer_display.f */
logic/fb_pkg.sv
logic/frame_memory.sv
logic/frame_arbiter.sv
logic/span_writer.sv
logic/scanout_reader.sv
logic/framebuffer_display.sv
bench/framebuffer_display_assertions.sv
bench/framebuffer_display_tb.sv

/* Bender.yml */
package:
  name: framebuffer_display

sources:
  # design, package first
  - logic/fb_pkg.sv
  - logic/frame_memory.sv
  - logic/frame_arbiter.sv
  - logic/span_writer.sv
  - logic/scanout_reader.sv
  - logic/framebuffer_display.sv
  # simulation only
  - target: test
    files:
      - bench/framebuffer_display_assertions.sv
      - bench/framebuffer_display_tb.sv
